//--- src/sv39_pkg.sv
package sv39_pkg;

  localparam int vaddr_width       = 39;
  localparam int paddr_width       = 56;
  localparam int ppn_width         = 44;
  localparam int page_offset_width = 12;
  localparam int page_idx_width    = 9;
  localparam int pt_levels         = 3;
  localparam int level_width       = 2;
  localparam int dword_width       = 64;
  localparam int pte_size_log2     = 3;
  localparam int vpn_width         = page_idx_width * pt_levels;

  localparam int pte_v_bit   = 0;
  localparam int pte_r_bit   = 1;
  localparam int pte_w_bit   = 2;
  localparam int pte_x_bit   = 3;
  localparam int pte_u_bit   = 4;
  localparam int pte_a_bit   = 6;
  localparam int pte_d_bit   = 7;
  localparam int pte_ppn_lsb = 10;

  localparam logic [1:0] kind_fetch = 2'd0;
  localparam logic [1:0] kind_load  = 2'd1;
  localparam logic [1:0] kind_store = 2'd2;

  // Replaces the PPN slices below the leaf level with VPN slices.
  function automatic logic [ppn_width-1:0] merge_ppn(
    input logic [ppn_width-1:0]   ppn,
    input logic [vpn_width-1:0]   vpn,
    input logic [level_width-1:0] level
  );
    logic [ppn_width-1:0] merged;
    merged = ppn;
    for (int i = 0; i < pt_levels-1; i++)
    begin
      if (level > i)
        merged[i*page_idx_width +: page_idx_width] = vpn[i*page_idx_width +: page_idx_width];
    end
    return merged;
  endfunction

  // Leaf checks for privilege, A/D bits and access kind.
  function automatic logic leaf_perm_fault(
    input logic [pte_d_bit:0] flags,
    input logic [1:0]         kind,
    input logic               user,
    input logic               sum,
    input logic               mxr
  );
    logic priv_fault;
    logic ad_fault;
    logic kind_fault;
    if (user)
      priv_fault = ~flags[pte_u_bit];
    else
      priv_fault = flags[pte_u_bit] & ((kind == kind_fetch) | ~sum);
    ad_fault = ~flags[pte_a_bit] | ((kind == kind_store) & ~flags[pte_d_bit]);
    case (kind)
      kind_fetch: kind_fault = ~flags[pte_x_bit];
      kind_load:  kind_fault = ~(flags[pte_r_bit] | (mxr & flags[pte_x_bit]));
      default:    kind_fault = ~flags[pte_w_bit];
    endcase
    return priv_fault | ad_fault | kind_fault;
  endfunction

endpackage

//--- src/pt_mem.sv
`timescale 1ns/1ps

module pt_mem
  #(parameter int pt_words_p = 1024
    , localparam int addr_width_lp = $clog2(pt_words_p)
    )
  (input                                  clk_i
   , input                                reset_i

   , input                                we_i
   , input [addr_width_lp-1:0]            waddr_i
   , input [sv39_pkg::dword_width-1:0]    wdata_i

   , input                                rd_v_i
   , input [sv39_pkg::paddr_width-1:0]    rd_addr_i
   , output logic                         rd_data_v_o
   , output logic [sv39_pkg::dword_width-1:0] rd_data_o
   );

  import sv39_pkg::*;

  logic [dword_width-1:0]   mem [pt_words_p];
  logic [addr_width_lp-1:0] rd_idx;

  // Doubleword index; upper address bits alias.
  assign rd_idx = rd_addr_i[pte_size_log2 +: addr_width_lp];

  always_ff @(posedge clk_i)
  begin
    if (we_i)
      mem[waddr_i] <= wdata_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (rd_v_i)
      rd_data_o <= mem[rd_idx];
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      rd_data_v_o <= 1'b0;
    else
      rd_data_v_o <= rd_v_i;
  end

endmodule

//--- src/ptw_walker.sv
`timescale 1ns/1ps

module ptw_walker
  (input                                    clk_i
   , input                                  reset_i

   , input                                  walk_start_i
   , input [sv39_pkg::vaddr_width-1:0]      vaddr_i
   , input [1:0]                            kind_i
   , input                                  user_i
   , input                                  sum_i
   , input                                  mxr_i
   , input [sv39_pkg::ppn_width-1:0]        satp_ppn_i

   , output logic                           rd_v_o
   , output logic [sv39_pkg::paddr_width-1:0] rd_addr_o
   , input                                  rd_data_v_i
   , input [sv39_pkg::dword_width-1:0]      rd_data_i

   , output logic                           walk_busy_o
   , output logic                           walk_done_o
   , output logic                           walk_fault_o
   , output logic [sv39_pkg::ppn_width-1:0] fill_ppn_o
   , output logic [sv39_pkg::level_width-1:0] fill_level_o
   , output logic [sv39_pkg::pte_d_bit:0]   fill_flags_o
   );

  import sv39_pkg::*;

  localparam logic [1:0] state_idle = 2'd0;
  localparam logic [1:0] state_send = 2'd1;
  localparam logic [1:0] state_wait = 2'd2;

  logic [1:0] state_r;
  logic [1:0] state_n;

  logic [vaddr_width-1:0] vaddr_r;
  logic [1:0]             kind_r;
  logic                   user_r;
  logic                   sum_r;
  logic                   mxr_r;
  logic [ppn_width-1:0]   ppn_r;
  logic [level_width-1:0] level_r;

  logic [vpn_width-1:0]      vpn;
  logic [page_idx_width-1:0] vpn_slice;

  logic [ppn_width-1:0] pte_ppn;
  logic [pte_d_bit:0]   pte_flags;
  logic                 pte_v;
  logic                 pte_r;
  logic                 pte_w;
  logic                 pte_x;
  logic                 pte_leaf;

  logic pte_invalid;
  logic leaf_not_found;
  logic misaligned;
  logic walk_fault;
  logic walk_end;
  logic start;
  logic walk_next;
  logic data_in;

  assign vpn       = vaddr_r[vaddr_width-1:page_offset_width];
  assign vpn_slice = vpn[level_r*page_idx_width +: page_idx_width];

  assign pte_ppn   = rd_data_i[pte_ppn_lsb +: ppn_width];
  assign pte_flags = rd_data_i[pte_d_bit:0];
  assign pte_v     = pte_flags[pte_v_bit];
  assign pte_r     = pte_flags[pte_r_bit];
  assign pte_w     = pte_flags[pte_w_bit];
  assign pte_x     = pte_flags[pte_x_bit];
  assign pte_leaf  = pte_r | pte_w | pte_x;

  assign pte_invalid    = ~pte_v | (pte_w & ~pte_r);
  assign leaf_not_found = (level_r == '0) & ~pte_leaf;

  // Superpage PPN must be zero below the leaf level.
  assign misaligned = (merge_ppn(pte_ppn, '0, level_r) != pte_ppn);

  assign walk_fault = pte_invalid | leaf_not_found
                    | (pte_leaf & (misaligned
                                   | leaf_perm_fault(pte_flags, kind_r, user_r, sum_r, mxr_r)));
  assign walk_end   = pte_leaf | walk_fault;

  assign start     = (state_r == state_idle) & walk_start_i;
  assign data_in   = (state_r == state_wait) & rd_data_v_i;
  assign walk_next = data_in & ~walk_end;

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      state_idle:
        if (walk_start_i)
          state_n = state_send;
      state_send:
        state_n = state_wait;
      state_wait:
        if (rd_data_v_i)
          state_n = walk_end ? state_idle : state_send;
      default:
        state_n = state_idle;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= state_idle;
    else
      state_r <= state_n;
  end

  always_ff @(posedge clk_i)
  begin
    if (start)
    begin
      vaddr_r <= vaddr_i;
      kind_r  <= kind_i;
      user_r  <= user_i;
      sum_r   <= sum_i;
      mxr_r   <= mxr_i;
      ppn_r   <= satp_ppn_i;
      level_r <= level_width'(pt_levels-1);
    end
    else if (walk_next)
    begin
      // Pointer to the next table.
      ppn_r   <= pte_ppn;
      level_r <= level_r - 1'b1;
    end
  end

  assign rd_v_o    = (state_r == state_send);
  assign rd_addr_o = {ppn_r, vpn_slice, {pte_size_log2{1'b0}}};

  assign walk_busy_o  = (state_r != state_idle);
  assign walk_done_o  = data_in & walk_end;
  assign walk_fault_o = walk_fault;
  assign fill_ppn_o   = merge_ppn(pte_ppn, vpn, level_r);
  assign fill_level_o = level_r;
  assign fill_flags_o = pte_flags;

endmodule

//--- src/sv39_tlb.sv
`timescale 1ns/1ps

module sv39_tlb
  #(parameter int tlb_entries_p = 4
    , localparam int idx_width_lp = (tlb_entries_p > 1) ? $clog2(tlb_entries_p) : 1
    )
  (input                                    clk_i
   , input                                  reset_i

   , input                                  req_v_i
   , input [sv39_pkg::vaddr_width-1:0]      req_vaddr_i
   , input [1:0]                            req_kind_i
   , input                                  priv_user_i
   , input                                  sum_i
   , input                                  mxr_i
   , input                                  flush_i
   , output logic                           busy_o

   , output logic                           walk_start_o
   , output logic [sv39_pkg::vaddr_width-1:0] walk_vaddr_o
   , output logic [1:0]                     walk_kind_o
   , output logic                           walk_user_o
   , output logic                           walk_sum_o
   , output logic                           walk_mxr_o
   , input                                  walk_busy_i
   , input                                  walk_done_i
   , input                                  walk_fault_i
   , input [sv39_pkg::ppn_width-1:0]        fill_ppn_i
   , input [sv39_pkg::level_width-1:0]      fill_level_i
   , input [sv39_pkg::pte_d_bit:0]          fill_flags_i

   , output logic                           resp_v_o
   , output logic                           resp_fault_o
   , output logic [sv39_pkg::paddr_width-1:0] resp_paddr_o
   );

  import sv39_pkg::*;

  localparam logic [1:0] state_idle   = 2'd0;
  localparam logic [1:0] state_lookup = 2'd1;
  localparam logic [1:0] state_walk   = 2'd2;
  localparam logic [1:0] state_resp   = 2'd3;

  logic [1:0] state_r;
  logic [1:0] state_n;

  logic [vaddr_width-1:0] vaddr_r;
  logic [1:0]             kind_r;
  logic                   user_r;
  logic                   sum_r;
  logic                   mxr_r;
  logic                   fault_r;
  logic [paddr_width-1:0] paddr_r;

  logic [tlb_entries_p-1:0] valid_r;
  logic [vpn_width-1:0]     tag_r   [tlb_entries_p];
  logic [ppn_width-1:0]     ppn_r   [tlb_entries_p];
  logic [level_width-1:0]   level_r [tlb_entries_p];
  logic [pte_d_bit:0]       flags_r [tlb_entries_p];
  logic [idx_width_lp-1:0]  victim_r;

  logic [vpn_width-1:0]     req_vpn;
  logic [tlb_entries_p-1:0] entry_hit;
  logic [idx_width_lp-1:0]  hit_idx;
  logic                     hit;
  logic [paddr_width-1:0]   hit_paddr;
  logic                     idle;
  logic                     accept;
  logic                     flush;
  logic                     fill;

  assign req_vpn = vaddr_r[vaddr_width-1:page_offset_width];
  assign idle    = (state_r == state_idle) & ~walk_busy_i;
  assign accept  = idle & req_v_i;
  assign flush   = idle & flush_i;
  assign fill    = (state_r == state_walk) & walk_done_i & ~walk_fault_i;

  // Tag compare skips VPN slices below the entry level.
  always_comb
  begin
    for (int i = 0; i < tlb_entries_p; i++)
    begin
      entry_hit[i] = valid_r[i]
                   & (((tag_r[i] ^ req_vpn)
                       & ({vpn_width{1'b1}} << (level_r[i]*page_idx_width))) == '0)
                   & ~leaf_perm_fault(flags_r[i], kind_r, user_r, sum_r, mxr_r);
    end
    hit_idx = '0;
    for (int i = tlb_entries_p-1; i >= 0; i--)
    begin
      if (entry_hit[i])
        hit_idx = idx_width_lp'(i);
    end
  end

  assign hit       = |entry_hit;
  assign hit_paddr = {merge_ppn(ppn_r[hit_idx], req_vpn, level_r[hit_idx]),
                      vaddr_r[page_offset_width-1:0]};

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      state_idle:
        if (accept)
          state_n = state_lookup;
      state_lookup:
        state_n = hit ? state_idle : state_walk;
      state_walk:
        if (walk_done_i)
          state_n = state_resp;
      default:
        state_n = state_idle;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= state_idle;
    else
      state_r <= state_n;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      vaddr_r <= req_vaddr_i;
      kind_r  <= req_kind_i;
      user_r  <= priv_user_i;
      sum_r   <= sum_i;
      mxr_r   <= mxr_i;
    end
    if ((state_r == state_walk) && walk_done_i)
    begin
      fault_r <= walk_fault_i;
      paddr_r <= {fill_ppn_i, vaddr_r[page_offset_width-1:0]};
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (fill)
    begin
      tag_r[victim_r]   <= req_vpn;
      ppn_r[victim_r]   <= fill_ppn_i;
      level_r[victim_r] <= fill_level_i;
      flags_r[victim_r] <= fill_flags_i;
    end
  end

  // Round-robin replacement.
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      valid_r  <= '0;
      victim_r <= '0;
    end
    else if (flush)
      valid_r <= '0;
    else if (fill)
    begin
      valid_r[victim_r] <= 1'b1;
      victim_r          <= victim_r + 1'b1;
    end
  end

  assign busy_o = (state_r != state_idle) | walk_busy_i;

  assign walk_start_o = (state_r == state_lookup) & ~hit;
  assign walk_vaddr_o = vaddr_r;
  assign walk_kind_o  = kind_r;
  assign walk_user_o  = user_r;
  assign walk_sum_o   = sum_r;
  assign walk_mxr_o   = mxr_r;

  assign resp_v_o     = ((state_r == state_lookup) & hit) | (state_r == state_resp);
  assign resp_fault_o = (state_r == state_resp) & fault_r;
  assign resp_paddr_o = (state_r == state_lookup) ? hit_paddr : paddr_r;

endmodule

//--- src/mmu_top.sv
`timescale 1ns/1ps

module mmu_top
  #(parameter int tlb_entries_p = 4
    , parameter int pt_words_p = 1024
    , localparam int mem_addr_width_lp = $clog2(pt_words_p)
    )
  (input                                    clk_i
   , input                                  reset_i

   , input                                  req_v_i
   , input [sv39_pkg::vaddr_width-1:0]      req_vaddr_i
   , input [1:0]                            req_kind_i
   , input                                  priv_user_i
   , input                                  sum_i
   , input                                  mxr_i
   , input [sv39_pkg::ppn_width-1:0]        satp_ppn_i
   , input                                  flush_i

   , input                                  mem_we_i
   , input [mem_addr_width_lp-1:0]          mem_addr_i
   , input [sv39_pkg::dword_width-1:0]      mem_wdata_i

   , output logic                           busy_o
   , output logic                           resp_v_o
   , output logic                           resp_fault_o
   , output logic [sv39_pkg::paddr_width-1:0] resp_paddr_o
   );

  import sv39_pkg::*;

  logic                   walk_start;
  logic [vaddr_width-1:0] walk_vaddr;
  logic [1:0]             walk_kind;
  logic                   walk_user;
  logic                   walk_sum;
  logic                   walk_mxr;
  logic                   walk_busy;
  logic                   walk_done;
  logic                   walk_fault;
  logic [ppn_width-1:0]   fill_ppn;
  logic [level_width-1:0] fill_level;
  logic [pte_d_bit:0]     fill_flags;
  logic                   rd_v;
  logic [paddr_width-1:0] rd_addr;
  logic                   rd_data_v;
  logic [dword_width-1:0] rd_data;

  sv39_tlb
   #(.tlb_entries_p(tlb_entries_p))
   tlb0
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.req_v_i(req_v_i)
     ,.req_vaddr_i(req_vaddr_i)
     ,.req_kind_i(req_kind_i)
     ,.priv_user_i(priv_user_i)
     ,.sum_i(sum_i)
     ,.mxr_i(mxr_i)
     ,.flush_i(flush_i)
     ,.busy_o(busy_o)
     ,.walk_start_o(walk_start)
     ,.walk_vaddr_o(walk_vaddr)
     ,.walk_kind_o(walk_kind)
     ,.walk_user_o(walk_user)
     ,.walk_sum_o(walk_sum)
     ,.walk_mxr_o(walk_mxr)
     ,.walk_busy_i(walk_busy)
     ,.walk_done_i(walk_done)
     ,.walk_fault_i(walk_fault)
     ,.fill_ppn_i(fill_ppn)
     ,.fill_level_i(fill_level)
     ,.fill_flags_i(fill_flags)
     ,.resp_v_o(resp_v_o)
     ,.resp_fault_o(resp_fault_o)
     ,.resp_paddr_o(resp_paddr_o)
     );

  ptw_walker
   walker0
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.walk_start_i(walk_start)
     ,.vaddr_i(walk_vaddr)
     ,.kind_i(walk_kind)
     ,.user_i(walk_user)
     ,.sum_i(walk_sum)
     ,.mxr_i(walk_mxr)
     ,.satp_ppn_i(satp_ppn_i)
     ,.rd_v_o(rd_v)
     ,.rd_addr_o(rd_addr)
     ,.rd_data_v_i(rd_data_v)
     ,.rd_data_i(rd_data)
     ,.walk_busy_o(walk_busy)
     ,.walk_done_o(walk_done)
     ,.walk_fault_o(walk_fault)
     ,.fill_ppn_o(fill_ppn)
     ,.fill_level_o(fill_level)
     ,.fill_flags_o(fill_flags)
     );

  pt_mem
   #(.pt_words_p(pt_words_p))
   mem0
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.we_i(mem_we_i)
     ,.waddr_i(mem_addr_i)
     ,.wdata_i(mem_wdata_i)
     ,.rd_v_i(rd_v)
     ,.rd_addr_i(rd_addr)
     ,.rd_data_v_o(rd_data_v)
     ,.rd_data_o(rd_data)
     );

endmodule

//--- tb/mmu_checker.sv
`timescale 1ns/1ps

module mmu_checker
  #(parameter int pt_words_p = 1024
    , localparam int addr_width_lp = $clog2(pt_words_p)
    )
  (input                                    clk_i
   , input                                  reset_i
   , input                                  req_v_i
   , input [sv39_pkg::vaddr_width-1:0]      req_vaddr_i
   , input [1:0]                            req_kind_i
   , input                                  priv_user_i
   , input                                  sum_i
   , input                                  mxr_i
   , input [sv39_pkg::ppn_width-1:0]        satp_ppn_i
   , input                                  busy_i
   , input                                  mem_we_i
   , input [addr_width_lp-1:0]              mem_addr_i
   , input [sv39_pkg::dword_width-1:0]      mem_wdata_i
   , input                                  resp_v_i
   , input                                  resp_fault_i
   , input [sv39_pkg::paddr_width-1:0]      resp_paddr_i
   , input                                  expect_hit_i
   , input                                  expect_cached_i
   , output int                             error_count_o
   , output int                             check_count_o
   );

  import sv39_pkg::*;

  logic [dword_width-1:0] mirror [pt_words_p];
  logic                   pending;
  logic                   exp_hit;
  logic                   exp_fault;
  logic [paddr_width-1:0] exp_paddr;
  logic                   last_fault;
  logic [paddr_width-1:0] last_paddr;
  int                     latency;

  initial
  begin
    error_count_o = 0;
    check_count_o = 0;
    pending = 1'b0;
    last_fault = 1'b1;
    last_paddr = '0;
  end

  // Three-level Sv39 walk over the mirrored memory.
  task automatic ref_walk(input logic [vaddr_width-1:0] va, input logic [1:0] kind,
                         input logic user, input logic sum, input logic mxr,
                         input logic [ppn_width-1:0] root,
                         output logic fault, output logic [paddr_width-1:0] pa);
    logic [ppn_width-1:0]   ppn;
    logic [ppn_width-1:0]   leaf_ppn;
    logic [ppn_width-1:0]   mask;
    logic [dword_width-1:0] pte;
    logic [ppn_width+8:0]   idx;
    logic                   done;
    ppn = root;
    fault = 1'b0;
    pa = '0;
    done = 1'b0;
    for (int lvl = 2; lvl >= 0; lvl--)
    begin
      if (!done)
      begin
        idx = {ppn, va[12+9*lvl +: 9]};
        pte = mirror[idx % pt_words_p];
        if (!pte[0] || (pte[2] && !pte[1]))
        begin
          fault = 1'b1;
          done = 1'b1;
        end
        else if (pte[1] || pte[3])
        begin
          done = 1'b1;
          leaf_ppn = pte[10 +: 44];
          mask = (44'd1 << (9*lvl)) - 44'd1;
          if ((leaf_ppn & mask) != '0)
            fault = 1'b1;
          if (user && !pte[4])
            fault = 1'b1;
          if (!user && pte[4] && (kind == kind_fetch || !sum))
            fault = 1'b1;
          if (!pte[6] || (kind == kind_store && !pte[7]))
            fault = 1'b1;
          if (kind == kind_fetch && !pte[3])
            fault = 1'b1;
          if (kind == kind_load && !(pte[1] || (mxr && pte[3])))
            fault = 1'b1;
          if (kind == kind_store && !pte[2])
            fault = 1'b1;
          pa = {(leaf_ppn & ~mask) | (44'(va[38:12]) & mask), va[11:0]};
        end
        else if (lvl == 0)
        begin
          fault = 1'b1;
          done = 1'b1;
        end
        else
          ppn = pte[10 +: 44];
      end
    end
  endtask

  always @(posedge clk_i)
  begin
    if (mem_we_i)
      mirror[mem_addr_i] = mem_wdata_i;
    if (reset_i)
      pending = 1'b0;
    else
    begin
      // Busy from acceptance through the response pulse.
      if (busy_i !== pending)
      begin
        $display("** Error at %0t: busy expected %0b, got %0b", $time, pending, busy_i);
        error_count_o++;
      end
      if (pending)
        latency++;
      if (resp_v_i)
      begin
        check_count_o++;
        if (!pending)
        begin
          $display("Response pulse arrived with no request outstanding at %0t", $time);
          error_count_o++;
        end
        else
        begin
          if (resp_fault_i !== exp_fault || (!exp_fault && resp_paddr_i !== exp_paddr))
          begin
            $display("** Error at %0t: fault/paddr expected %0b/%h, got %0b/%h",
                     $time, exp_fault, exp_paddr, resp_fault_i, resp_paddr_i);
            error_count_o++;
          end
          if (exp_hit && latency != 1)
          begin
            $display("** Error at %0t: hit latency expected 1, got %0d", $time, latency);
            error_count_o++;
          end
          last_fault = exp_fault;
          last_paddr = exp_paddr;
          pending = 1'b0;
        end
      end
      if (req_v_i && !busy_i)
      begin
        if (expect_cached_i)
        begin
          exp_fault = last_fault;
          exp_paddr = last_paddr;
        end
        else
          ref_walk(req_vaddr_i, req_kind_i, priv_user_i, sum_i, mxr_i, satp_ppn_i,
                   exp_fault, exp_paddr);
        exp_hit = expect_hit_i;
        latency = 0;
        pending = 1'b1;
      end
    end
  end

endmodule

//--- tb/mmu_tb.sv
`timescale 1ns/1ps

module mmu_tb;

  import sv39_pkg::*;

  localparam int tlb_entries_p  = 4;
  localparam int pt_words_p     = 1024;
  localparam int addr_width_lp  = $clog2(pt_words_p);
  localparam int timeout_cycles = 64;
  localparam logic [7:0] full_flags = 8'hdf;

  logic                     clk_i = 1'b0;
  logic                     reset_i;
  logic                     req_v_i;
  logic [vaddr_width-1:0]   req_vaddr_i;
  logic [1:0]               req_kind_i;
  logic                     priv_user_i;
  logic                     sum_i;
  logic                     mxr_i;
  logic [ppn_width-1:0]     satp_ppn_i;
  logic                     flush_i;
  logic                     mem_we_i;
  logic [addr_width_lp-1:0] mem_addr_i;
  logic [dword_width-1:0]   mem_wdata_i;
  logic                     busy_o;
  logic                     resp_v_o;
  logic                     resp_fault_o;
  logic [paddr_width-1:0]   resp_paddr_o;
  logic                     expect_hit;
  logic                     expect_cached;
  int                       error_count;
  int                       check_count;
  int                       seed = 76701;
  int                       tests_passed = 0;
  int                       tests_failed = 0;
  int                       timeouts = 0;
  int                       base_errors = 0;

  mmu_top #(.tlb_entries_p(tlb_entries_p), .pt_words_p(pt_words_p)) dut0
    (.clk_i, .reset_i, .req_v_i, .req_vaddr_i, .req_kind_i, .priv_user_i, .sum_i, .mxr_i,
     .satp_ppn_i, .flush_i, .mem_we_i, .mem_addr_i, .mem_wdata_i,
     .busy_o, .resp_v_o, .resp_fault_o, .resp_paddr_o);

  mmu_checker #(.pt_words_p(pt_words_p)) chk0
    (.clk_i, .reset_i, .req_v_i, .req_vaddr_i, .req_kind_i, .priv_user_i, .sum_i, .mxr_i,
     .satp_ppn_i, .busy_i(busy_o), .mem_we_i, .mem_addr_i, .mem_wdata_i,
     .resp_v_i(resp_v_o), .resp_fault_i(resp_fault_o), .resp_paddr_i(resp_paddr_o),
     .expect_hit_i(expect_hit), .expect_cached_i(expect_cached),
     .error_count_o(error_count), .check_count_o(check_count));

  always #2 clk_i = ~clk_i;

  task automatic write_word(input logic [addr_width_lp-1:0] addr, input logic [63:0] data);
    @(posedge clk_i);
    mem_we_i    <= 1'b1;
    mem_addr_i  <= addr;
    mem_wdata_i <= data;
    @(posedge clk_i);
    mem_we_i    <= 1'b0;
  endtask

  function automatic logic [63:0] make_pte(input logic [43:0] ppn, input logic [7:0] flags);
    return {10'd0, ppn, 2'b00, flags};
  endfunction

  function automatic logic [43:0] rand_ppn();
    return {$random(seed), $random(seed)};
  endfunction

  // Root table in page 0, level-1 table in page 1, level-0 table back in page 0.
  function automatic logic [38:0] rand_vaddr();
    logic [8:0]  s2;
    logic [8:0]  s1;
    logic [8:0]  s0;
    logic [11:0] off;
    s2  = 9'($random(seed) & 8'hff);
    s1  = 9'($random(seed));
    s0  = 9'd256 + 9'($random(seed) & 8'hff);
    off = 12'($random(seed));
    return {s2, s1, s0, off};
  endfunction

  task automatic build_path(input logic [38:0] va, input int level, input logic [63:0] leaf);
    write_word({1'b0, va[38:30]}, (level == 2) ? leaf : make_pte(44'd1, 8'h01));
    if (level < 2)
      write_word({1'b1, va[29:21]}, (level == 1) ? leaf : make_pte(44'd0, 8'h01));
    if (level == 0)
      write_word({1'b0, va[20:12]}, leaf);
  endtask

  task automatic flush();
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
  endtask

  task automatic translate(input logic [38:0] va, input logic [1:0] kind, input logic user,
                           input logic sum, input logic mxr, input logic hit, input logic cached);
    int cycles;
    cycles = 0;
    while (busy_o && cycles < timeout_cycles)
    begin
      @(posedge clk_i);
      cycles++;
    end
    if (busy_o)
    begin
      $display("DUT still busy after timeout before request for vaddr %h at %0t", va, $time);
      timeouts++;
    end
    @(posedge clk_i);
    req_v_i       <= 1'b1;
    req_vaddr_i   <= va;
    req_kind_i    <= kind;
    priv_user_i   <= user;
    sum_i         <= sum;
    mxr_i         <= mxr;
    expect_hit    <= hit;
    expect_cached <= cached;
    @(posedge clk_i);
    req_v_i       <= 1'b0;
    expect_hit    <= 1'b0;
    expect_cached <= 1'b0;
    cycles = 0;
    @(posedge clk_i);
    cycles++;
    while (!resp_v_o && cycles < timeout_cycles)
    begin
      @(posedge clk_i);
      cycles++;
    end
    if (!resp_v_o)
    begin
      $display("No response within timeout for vaddr %h at %0t", va, $time);
      timeouts++;
    end
  endtask

  task automatic run_case(input logic [38:0] va, input int level, input logic [63:0] leaf,
                          input logic [1:0] kind, input logic user, input logic sum,
                          input logic mxr);
    flush();
    build_path(va, level, leaf);
    translate(va, kind, user, sum, mxr, 1'b0, 1'b0);
  endtask

  task automatic end_test(input string name);
    int errs;
    @(posedge clk_i);
    errs = error_count + timeouts - base_errors;
    base_errors = error_count + timeouts;
    if (errs == 0)
      tests_passed++;
    else
      tests_failed++;
    $display("%s: %s (%0d errors, %0d checks so far)", name, (errs == 0) ? "pass" : "fail",
             errs, check_count);
  endtask

  initial
  begin
    logic [38:0] va;
    logic [43:0] ppn;
    logic [7:0]  flags [7];
    reset_i = 1'b1;
    req_v_i = 1'b0;
    req_vaddr_i = '0;
    req_kind_i = kind_load;
    priv_user_i = 1'b1;
    sum_i = 1'b0;
    mxr_i = 1'b0;
    satp_ppn_i = '0;
    flush_i = 1'b0;
    mem_we_i = 1'b0;
    mem_addr_i = '0;
    mem_wdata_i = '0;
    expect_hit = 1'b0;
    expect_cached = 1'b0;
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;
    // Invalid entries that carry their own index.
    for (int i = 0; i < pt_words_p; i++)
      write_word(addr_width_lp'(i), 64'(i) << 10);

    for (int n = 0; n < 20; n++)
      run_case(rand_vaddr(), 0, make_pte(rand_ppn(), full_flags), 2'({$random(seed)} % 3),
               1'b1, 1'b0, 1'b0);
    end_test("kilopage translation");

    for (int n = 0; n < 8; n++)
    begin
      for (int lvl = 1; lvl <= 2; lvl++)
      begin
        ppn = rand_ppn() & ~((44'd1 << (9*lvl)) - 44'd1);
        run_case(rand_vaddr(), lvl, make_pte(ppn, full_flags), kind_load, 1'b1, 1'b0, 1'b0);
        ppn = ppn | 44'(1 + ({$random(seed)} % 500));
        run_case(rand_vaddr(), lvl, make_pte(ppn, full_flags), kind_load, 1'b1, 1'b0, 1'b0);
      end
    end
    end_test("superpages");

    flags[0] = full_flags & ~8'h01;
    flags[1] = full_flags & ~8'h02;
    flags[2] = 8'h01;
    flags[3] = full_flags & ~8'h80;
    flags[4] = full_flags & ~8'h40;
    flags[5] = full_flags & ~8'h08;
    flags[6] = 8'hd9;
    for (int c = 0; c < 7; c++)
      for (int k = 0; k < 3; k++)
        for (int m = 0; m < 2; m++)
          run_case(rand_vaddr(), 0, make_pte(rand_ppn(), flags[c]), 2'(k), 1'b1, 1'b0, m[0]);
    end_test("structural and permission faults");

    for (int k = 0; k < 3; k++)
    begin
      run_case(rand_vaddr(), 0, make_pte(rand_ppn(), full_flags & ~8'h10), 2'(k),
               1'b1, 1'b0, 1'b0);
      for (int s = 0; s < 2; s++)
        run_case(rand_vaddr(), 0, make_pte(rand_ppn(), full_flags), 2'(k), 1'b0, s[0], 1'b0);
    end
    end_test("privilege");

    va = rand_vaddr();
    run_case(va, 0, make_pte(rand_ppn(), full_flags), kind_load, 1'b1, 1'b0, 1'b0);
    translate(va, kind_load, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
    write_word({1'b0, va[20:12]}, make_pte(rand_ppn(), full_flags));
    translate(va, kind_load, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1);
    flush();
    translate(va, kind_load, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    end_test("TLB reuse and flush");

    $display("Tests: %0d passed, %0d failed", tests_passed, tests_failed);
    if (tests_failed == 0 && error_count == 0 && timeouts == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- files.f
src/sv39_pkg.sv
src/pt_mem.sv
src/ptw_walker.sv
src/sv39_tlb.sv
src/mmu_top.sv
tb/mmu_checker.sv
tb/mmu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= mmu_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= TESTS PASSED

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
